//--- Makefile
# Verilator build of the rename core testbench

SOURCES := $(shell cat build.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vrename_core_tb: build.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module rename_core_tb

# pass only when the pass line shows up in the output
run: obj_dir/Vrename_core_tb
	@out="$$(./obj_dir/Vrename_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- build.f
verilog/rename_pkg.sv
verilog/rename_ifs.sv
verilog/rename_control.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
sim/rename_core_tb.sv

//--- sim/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;
  import rename_pkg::*;

  logic clock, reset;
  logic dispatch_valid, dispatch_ready;
  arch_reg_t dispatch_dest, dispatch_src_a, dispatch_src_b;
  phys_reg_t src_a_tag, src_b_tag, new_tag, old_tag;
  logic src_a_ready, src_b_ready;
  logic complete_valid;
  phys_reg_t complete_tag;
  logic retire_valid;
  arch_reg_t retire_arch;
  phys_reg_t retire_new_tag, retire_old_tag;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // speculative map and ready bits
  phys_reg_t m_map [num_arch_regs];
  logic [num_arch_regs-1:0] m_ready;
  // free tags, next one out first
  phys_reg_t free_q [$];
  // outstanding renames in program order
  arch_reg_t ren_dest [$];
  phys_reg_t ren_new [$];
  phys_reg_t ren_old [$];
  logic ren_done [$];
  // tags held by the map or by an in-flight rename
  logic [num_phys_regs-1:0] tag_busy;
  // low in reset and in the fill cycle after it
  logic filled;
  // expectations for the coming rising edge
  logic exp_ready, exp_a_ready, exp_b_ready, exp_retire, exp_tag_free;
  phys_reg_t exp_a_tag, exp_b_tag, exp_new_tag, exp_old_tag, exp_ret_new, exp_ret_old;
  arch_reg_t exp_ret_arch;
  int check_errors = 0;
  int timeout_errors = 0;

  rename_core dut (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // model follows the same edge as the DUT
  always @(posedge clock) begin
    if (reset) begin
      tag_busy = '0;
      for (int i = 0; i < num_arch_regs; i++) begin
        m_map[i] = phys_reg_t'(i);
        tag_busy[i] = 1'b1;
      end
      m_ready = '1;
      free_q = {};
      for (int i = 0; i < free_depth; i++)
        free_q.push_back(phys_reg_t'(num_arch_regs + i));
      ren_dest = {};
      ren_new = {};
      ren_old = {};
      ren_done = {};
      filled = 1'b0;
    end else begin
      // broadcast first, a rename of the same dest wins
      if (complete_valid) begin
        for (int i = 0; i < num_arch_regs; i++)
          if (m_map[i] == complete_tag)
            m_ready[i] = 1'b1;
        for (int i = 0; i < ren_new.size(); i++)
          if (ren_new[i] == complete_tag)
            ren_done[i] = 1'b1;
      end
      // oldest rename leaves, its old tag goes to the back
      if (exp_retire) begin
        free_q.push_back(ren_old[0]);
        tag_busy[ren_old[0]] = 1'b0;
        void'(ren_dest.pop_front());
        void'(ren_new.pop_front());
        void'(ren_old.pop_front());
        void'(ren_done.pop_front());
      end
      if (dispatch_valid && exp_ready) begin
        ren_dest.push_back(dispatch_dest);
        ren_new.push_back(free_q[0]);
        ren_old.push_back(m_map[dispatch_dest]);
        ren_done.push_back(1'b0);
        tag_busy[free_q[0]] = 1'b1;
        m_map[dispatch_dest] = free_q.pop_front();
        m_ready[dispatch_dest] = 1'b0;
      end
      filled = 1'b1;
    end
  end

  function automatic void compute_expect();
    exp_ready = filled && (ren_new.size() < rob_depth);
    exp_a_tag = m_map[dispatch_src_a];
    exp_a_ready = m_ready[dispatch_src_a];
    exp_b_tag = m_map[dispatch_src_b];
    exp_b_ready = m_ready[dispatch_src_b];
    exp_old_tag = m_map[dispatch_dest];
    exp_new_tag = (free_q.size() != 0) ? free_q[0] : '0;
    exp_tag_free = !tag_busy[new_tag];
    exp_retire = (ren_new.size() != 0) && ren_done[0];
    exp_ret_arch = exp_retire ? ren_dest[0] : '0;
    exp_ret_new = exp_retire ? ren_new[0] : '0;
    exp_ret_old = exp_retire ? ren_old[0] : '0;
  endfunction

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic apply_inputs(input logic dv, input logic cv, input phys_reg_t ct);
    dispatch_valid = dv;
    dispatch_dest = arch_reg_t'($urandom);
    dispatch_src_a = arch_reg_t'($urandom);
    dispatch_src_b = arch_reg_t'($urandom);
    complete_valid = cv;
    complete_tag = ct;
    compute_expect();
  endtask

  task automatic step(input logic dv);
    @(negedge clock);
    apply_inputs(dv, 1'b0, '0);
  endtask

  // random dispatch, random pending tag on the broadcast
  task automatic random_cycle();
    int pend [$];
    logic cv;
    phys_reg_t ct;
    @(negedge clock);
    cv = 1'b0;
    ct = '0;
    for (int i = 0; i < ren_new.size(); i++)
      if (!ren_done[i])
        pend.push_back(i);
    if (pend.size() != 0 && ($urandom % 3) != 0) begin
      cv = 1'b1;
      ct = ren_new[pend[$urandom % pend.size()]];
    end
    apply_inputs(($urandom % 4) != 0, cv, ct);
  endtask

  // broadcast the oldest pending tag each cycle until the DUT has retired everything
  task automatic drain_window();
    int retired;
    int target;
    int cycles;
    int idx;
    // a dispatch or retirement already set up for the coming edge counts too
    target = ren_new.size() + int'(dispatch_valid && dispatch_ready);
    retired = int'(retire_valid);
    cycles = 0;
    while (retired < target && cycles < 100) begin
      @(negedge clock);
      if (retire_valid)
        retired++;
      idx = -1;
      for (int i = ren_new.size() - 1; i >= 0; i--)
        if (!ren_done[i])
          idx = i;
      if (idx >= 0)
        apply_inputs(1'b0, 1'b1, ren_new[idx]);
      else
        apply_inputs(1'b0, 1'b0, '0);
      cycles++;
    end
    if (retired < target) begin
      timeout_errors++;
      $display("timeout: only %0d of %0d renames retired", retired, target);
    end
  endtask

  initial begin
    int cycles;
    void'($urandom(32'h0528_c39a));
    reset = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    complete_valid = 1'b0;
    complete_tag = '0;
    repeat (4) @(negedge clock);
    reset = 1'b0;
    apply_inputs(1'b0, 1'b0, '0);
    // fill the window with no broadcasts until the DUT stalls
    cycles = 0;
    step(1'b1);
    while (dispatch_ready && cycles < 20) begin
      step(1'b1);
      cycles++;
    end
    if (dispatch_ready) begin
      timeout_errors++;
      $display("timeout: dispatch_ready never dropped with the window filling");
    end
    // ninth dispatch held against a full window
    repeat (4) step(1'b1);
    // youngest first, nothing may retire before the oldest completes
    for (int i = ren_new.size() - 1; i >= 0; i--) begin
      @(negedge clock);
      apply_inputs(1'b0, 1'b1, ren_new[i]);
    end
    drain_window();
    repeat (600) random_cycle();
    drain_window();
    step(1'b0);
    $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic value_error(input string name, input int expected, input int actual);
    check_errors++;
    $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
  endtask

  // stall exactly when eight renames are in flight
  a_ready: assert property (@(posedge clock) disable iff (reset) dispatch_ready == exp_ready)
    else value_error("dispatch_ready", int'($sampled(exp_ready)), int'($sampled(dispatch_ready)));
  a_src_a_tag: assert property (@(posedge clock) disable iff (reset) src_a_tag == exp_a_tag)
    else value_error("src_a_tag", int'($sampled(exp_a_tag)), int'($sampled(src_a_tag)));
  a_src_a_ready: assert property (@(posedge clock) disable iff (reset) src_a_ready == exp_a_ready)
    else value_error("src_a_ready", int'($sampled(exp_a_ready)), int'($sampled(src_a_ready)));
  a_src_b_tag: assert property (@(posedge clock) disable iff (reset) src_b_tag == exp_b_tag)
    else value_error("src_b_tag", int'($sampled(exp_b_tag)), int'($sampled(src_b_tag)));
  a_src_b_ready: assert property (@(posedge clock) disable iff (reset) src_b_ready == exp_b_ready)
    else value_error("src_b_ready", int'($sampled(exp_b_ready)), int'($sampled(src_b_ready)));
  a_old_tag: assert property (@(posedge clock) disable iff (reset) old_tag == exp_old_tag)
    else value_error("old_tag", int'($sampled(exp_old_tag)), int'($sampled(old_tag)));
  // head of the free queue, recycled tags after the initial ones
  a_new_tag: assert property (@(posedge clock) disable iff (reset)
    dispatch_valid && exp_ready |-> new_tag == exp_new_tag)
    else value_error("new_tag", int'($sampled(exp_new_tag)), int'($sampled(new_tag)));
  a_tag_unused: assert property (@(posedge clock) disable iff (reset)
    dispatch_valid && exp_ready |-> exp_tag_free)
    else begin
      check_errors++;
      $display("new_tag %0d handed out while still in use at %0t", $sampled(new_tag), $time);
    end
  // in order, and only once the head is broadcast
  a_retire: assert property (@(posedge clock) disable iff (reset) retire_valid == exp_retire)
    else value_error("retire_valid", int'($sampled(exp_retire)), int'($sampled(retire_valid)));
  a_retire_arch: assert property (@(posedge clock) disable iff (reset)
    exp_retire |-> retire_arch == exp_ret_arch)
    else value_error("retire_arch", int'($sampled(exp_ret_arch)), int'($sampled(retire_arch)));
  a_retire_new: assert property (@(posedge clock) disable iff (reset)
    exp_retire |-> retire_new_tag == exp_ret_new)
    else value_error("retire_new_tag", int'($sampled(exp_ret_new)),
                     int'($sampled(retire_new_tag)));
  a_retire_old: assert property (@(posedge clock) disable iff (reset)
    exp_retire |-> retire_old_tag == exp_ret_old)
    else value_error("retire_old_tag", int'($sampled(exp_ret_old)),
                     int'($sampled(retire_old_tag)));

endmodule

//--- verilog/free_list.sv
`timescale 1ns/1ps

module free_list (
  input  logic     clock,
  input  logic     reset,
  dispatch_if.free disp,
  retire_if.free   ret
);
  import rename_pkg::*;

  typedef logic [$clog2(free_depth)-1:0] free_ptr_t;

  // circular queue of unused tags
  phys_reg_t queue [free_depth];
  // next tag handed out
  free_ptr_t head;
  // slot for the next returned tag
  free_ptr_t tail;
  count_t count;

  assign disp.new_tag = queue[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= count_t'(free_depth);
      // tags above the identity map, lowest first
      for (int i = 0; i < free_depth; i++) begin
        queue[i] <= phys_reg_t'(num_arch_regs + i);
      end
    end else begin
      // pop on every rename
      if (disp.fire) begin
        head <= head + free_ptr_t'(1);
      end
      // retired old tag goes to the back
      if (ret.valid) begin
        queue[tail] <= ret.old_tag;
        tail <= tail + free_ptr_t'(1);
      end
      if (disp.fire && !ret.valid) begin
        count <= count - count_t'(1);
      end else if (ret.valid && !disp.fire) begin
        count <= count + count_t'(1);
      end
    end
  end

  // a full queue means nothing is in flight to retire
  a_push_no_overflow: assert property (@(posedge clock) disable iff (reset)
    ret.valid |-> count < count_t'(free_depth));

  // control's grant must agree with the local occupancy
  a_pop_not_empty: assert property (@(posedge clock) disable iff (reset)
    disp.fire |-> count != '0);

endmodule

//--- verilog/map_table.sv
`timescale 1ns/1ps

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  dispatch_if.map               disp,
  input  logic                  complete_valid,
  input  rename_pkg::phys_reg_t complete_tag,
  output rename_pkg::phys_reg_t src_a_tag,
  output rename_pkg::phys_reg_t src_b_tag,
  output logic                  src_a_ready,
  output logic                  src_b_ready
);
  import rename_pkg::*;

  // speculative mapping per architectural register
  phys_reg_t map_tag [num_arch_regs];
  // set once the mapped tag has been broadcast
  logic [num_arch_regs-1:0] map_ready;
  // registers whose current tag is on the broadcast
  logic [num_arch_regs-1:0] cdb_match;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // reads see the state of the last edge, no bypass
  assign src_a_tag = map_tag[disp.src_a];
  assign src_b_tag = map_tag[disp.src_b];
  assign src_a_ready = map_ready[disp.src_a];
  assign src_b_ready = map_ready[disp.src_b];
  // previous producer of dest, kept by the reorder buffer
  assign disp.old_tag = map_tag[disp.dest];

  // broadcast compare against every entry
  always_comb begin
    for (int i = 0; i < num_arch_regs; i++) begin
      cdb_match[i] = complete_valid && (map_tag[i] == complete_tag);
    end
  end

  ////////////////////////////////////////
  // update
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int i = 0; i < num_arch_regs; i++) begin
        map_tag[i] <= phys_reg_t'(i);
        map_ready[i] <= 1'b1;
      end
    end else begin
      map_ready <= map_ready | cdb_match;
      // a rename of dest overrides a broadcast of its old tag
      if (disp.fire) begin
        map_tag[disp.dest] <= disp.new_tag;
        map_ready[disp.dest] <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/rename_control.sv
`timescale 1ns/1ps

module rename_control (
  input  logic       clock,
  input  logic       reset,
  input  logic       dispatch_valid,
  output logic       dispatch_ready,
  dispatch_if.control disp,
  retire_if.control  ret
);
  import rename_pkg::*;

  control_state_t state;
  // entries in the reorder buffer
  count_t rob_count;
  // tags waiting in the free list
  count_t free_count;
  count_t rob_count_next;
  count_t free_count_next;

  // grant only from the run state
  assign dispatch_ready = (state == ctl_run);
  // the single point where a rename is decided
  assign disp.fire = dispatch_valid && dispatch_ready;

  // dispatch takes a tag and a slot, retirement gives both back
  always_comb begin
    rob_count_next = rob_count;
    free_count_next = free_count;
    if (disp.fire && !ret.valid) begin
      rob_count_next = rob_count + count_t'(1);
      free_count_next = free_count - count_t'(1);
    end else if (ret.valid && !disp.fire) begin
      rob_count_next = rob_count - count_t'(1);
      free_count_next = free_count + count_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ctl_reset_fill;
      rob_count <= '0;
      free_count <= count_t'(free_depth);
    end else begin
      rob_count <= rob_count_next;
      free_count <= free_count_next;
      // stall decided from the counts seen next cycle
      if (free_count_next == '0 || rob_count_next == count_t'(rob_depth)) begin
        state <= ctl_stalled;
      end else begin
        state <= ctl_run;
      end
    end
  end

  // state is a cycle behind the counts, both must still agree
  a_fire_has_room: assert property (@(posedge clock) disable iff (reset)
    disp.fire |-> (free_count != '0) && (rob_count != count_t'(rob_depth)));

  // reorder buffer never retires from an empty window
  a_retire_nonempty: assert property (@(posedge clock) disable iff (reset)
    ret.valid |-> rob_count != '0);

endmodule

//--- verilog/rename_core.sv
`timescale 1ns/1ps

module rename_core (
  input  logic                  clock,
  input  logic                  reset,
  // dispatch handshake
  input  logic                  dispatch_valid,
  output logic                  dispatch_ready,
  input  rename_pkg::arch_reg_t dispatch_dest,
  input  rename_pkg::arch_reg_t dispatch_src_a,
  input  rename_pkg::arch_reg_t dispatch_src_b,
  // rename results, same cycle as the dispatch
  output rename_pkg::phys_reg_t src_a_tag,
  output logic                  src_a_ready,
  output rename_pkg::phys_reg_t src_b_tag,
  output logic                  src_b_ready,
  output rename_pkg::phys_reg_t new_tag,
  output rename_pkg::phys_reg_t old_tag,
  // completion broadcast
  input  logic                  complete_valid,
  input  rename_pkg::phys_reg_t complete_tag,
  // retirement
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_arch,
  output rename_pkg::phys_reg_t retire_new_tag,
  output rename_pkg::phys_reg_t retire_old_tag
);
  import rename_pkg::*;

  dispatch_if disp_bus ();
  retire_if ret_bus ();

  // architectural fields straight from the port
  assign disp_bus.dest = dispatch_dest;
  assign disp_bus.src_a = dispatch_src_a;
  assign disp_bus.src_b = dispatch_src_b;
  assign new_tag = disp_bus.new_tag;
  assign old_tag = disp_bus.old_tag;

  assign retire_valid = ret_bus.valid;
  assign retire_arch = ret_bus.arch_dest;
  assign retire_new_tag = ret_bus.new_tag;
  assign retire_old_tag = ret_bus.old_tag;

  rename_control u_control (
    .clock(clock), .reset(reset), .dispatch_valid(dispatch_valid),
    .dispatch_ready(dispatch_ready), .disp(disp_bus), .ret(ret_bus)
  );

  // broadcast feeds both the map and the window
  map_table u_map (
    .clock(clock), .reset(reset), .disp(disp_bus),
    .complete_valid(complete_valid), .complete_tag(complete_tag),
    .src_a_tag(src_a_tag), .src_b_tag(src_b_tag),
    .src_a_ready(src_a_ready), .src_b_ready(src_b_ready)
  );

  free_list u_free (.clock(clock), .reset(reset), .disp(disp_bus), .ret(ret_bus));

  reorder_buffer u_rob (
    .clock(clock), .reset(reset), .disp(disp_bus), .ret(ret_bus),
    .complete_valid(complete_valid), .complete_tag(complete_tag)
  );

endmodule

//--- verilog/rename_ifs.sv
`timescale 1ns/1ps

// one rename per cycle
// all fields belong to the cycle in which fire is high
interface dispatch_if;
  import rename_pkg::*;

  // rename happens this cycle
  logic fire;
  // architectural fields from the dispatch port
  arch_reg_t dest;
  arch_reg_t src_a;
  arch_reg_t src_b;
  // head of the free list
  phys_reg_t new_tag;
  // mapping of dest before this rename
  phys_reg_t old_tag;

  modport control (output fire);
  modport map (input fire, dest, src_a, src_b, new_tag, output old_tag);
  modport free (input fire, output new_tag);
  modport rob (input fire, dest, new_tag, old_tag);
endinterface

// oldest completed rename leaving the window
interface retire_if;
  import rename_pkg::*;

  logic valid;
  arch_reg_t arch_dest;
  phys_reg_t new_tag;
  // goes back on the free list
  phys_reg_t old_tag;

  modport rob (output valid, arch_dest, new_tag, old_tag);
  modport free (input valid, old_tag);
  modport control (input valid);
endinterface

//--- verilog/rename_pkg.sv
package rename_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // architectural register file
  localparam int num_arch_regs = 8;
  // physical tags, mapped and free together
  localparam int num_phys_regs = 16;
  // in-flight renames
  localparam int rob_depth = 8;
  // tags left over once every arch reg holds one
  localparam int free_depth = num_phys_regs - num_arch_regs;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // architectural register index
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;
  // physical register tag
  typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;
  // reorder buffer slot
  typedef logic [$clog2(rob_depth)-1:0] rob_ptr_t;
  // occupancy, one wider so a full count fits
  typedef logic [$clog2(rob_depth):0] count_t;

  // dispatch control
  // reset_fill only lasts the cycle after reset
  typedef enum logic [1:0] {
    ctl_reset_fill,
    ctl_run,
    ctl_stalled
  } control_state_t;

endpackage

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  dispatch_if.rob               disp,
  retire_if.rob                 ret,
  input  logic                  complete_valid,
  input  rename_pkg::phys_reg_t complete_tag
);
  import rename_pkg::*;

  // oldest entry
  rob_ptr_t head;
  // next free slot
  rob_ptr_t tail;
  // per-entry control bits
  logic [rob_depth-1:0] entry_valid;
  logic [rob_depth-1:0] entry_done;
  // per-entry payload
  arch_reg_t entry_dest [rob_depth];
  phys_reg_t entry_new [rob_depth];
  phys_reg_t entry_old [rob_depth];
  // entries matched by this cycle's broadcast
  logic [rob_depth-1:0] cdb_hit;

  // broadcast search over the whole window
  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      cdb_hit[i] = complete_valid && entry_valid[i] && !entry_done[i] &&
                   (entry_new[i] == complete_tag);
    end
  end

  ////////////////////////////////////////
  // retire port
  ////////////////////////////////////////

  // in order, head only
  assign ret.valid = entry_valid[head] && entry_done[head];
  assign ret.arch_dest = entry_dest[head];
  assign ret.new_tag = entry_new[head];
  assign ret.old_tag = entry_old[head];

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      entry_valid <= '0;
      entry_done <= '0;
    end else begin
      entry_done <= entry_done | cdb_hit;
      if (ret.valid) begin
        entry_valid[head] <= 1'b0;
        head <= head + rob_ptr_t'(1);
      end
      // new entry waits for its broadcast
      if (disp.fire) begin
        entry_valid[tail] <= 1'b1;
        entry_done[tail] <= 1'b0;
        tail <= tail + rob_ptr_t'(1);
      end
    end
  end

  // payload written at tail, read at head
  always_ff @(posedge clock) begin
    if (disp.fire) begin
      entry_dest[tail] <= disp.dest;
      entry_new[tail] <= disp.new_tag;
      entry_old[tail] <= disp.old_tag;
    end
  end

  // each tag completes once, for exactly one in-flight rename
  a_cdb_one_hit: assert property (@(posedge clock) disable iff (reset)
    complete_valid |-> $onehot(cdb_hit));

  // grant from control never lands on a live slot
  a_tail_free: assert property (@(posedge clock) disable iff (reset)
    disp.fire |-> !entry_valid[tail]);

endmodule
